// File: Bender.yml
package:
  name: nand_flash

export_include_dirs:
  - .

sources:
  - nand_pkg.sv
  - nand_cmd_decoder.sv
  - nand_page_cache.sv
  - nand_array_engine.sv
  - nand_flash_top.sv
  - target: test
    files:
      - tb_nand_flash.sv

// File: all.f
+incdir+.
nand_pkg.sv
nand_cmd_decoder.sv
nand_page_cache.sv
nand_array_engine.sv
nand_flash_top.sv
tb_nand_flash.sv

// File: nand_array_engine.sv
// One operation at a time; the array comes up all FF on reset and keeps no per-page program count
`default_nettype none

`include "nand_cfg.svh"

module nand_array_engine (
    input  logic                  RE_B,
    input  logic                  CE_B,
    input  nand_pkg::op_req_t     req,
    output nand_pkg::cache_port_t cache,
    input  nand_pkg::byte_t       cache_rdata,
    output logic                  ryby
);

    localparam int PAGE_LEN    = `NAND_PAGE_BYTES;
    localparam int BLOCK_LEN   = `NAND_PAGES_PER_BLOCK * `NAND_PAGE_BYTES;
    localparam int ARRAY_BYTES = `NAND_BLOCKS * BLOCK_LEN;
    localparam int ADDR_W      = `NAND_ROW_W + `NAND_COL_W;
    localparam int BLK_W       = $clog2(`NAND_BLOCKS);
    localparam int SUB_W       = ADDR_W - BLK_W; // Page and column bits inside a block
    localparam int T_MAX       = (`NAND_T_PROG > `NAND_T_ERASE) ? `NAND_T_PROG : `NAND_T_ERASE;
    localparam int W_MAX       = (`NAND_T_READ > T_MAX) ? `NAND_T_READ : T_MAX;
    localparam int CNT_MAX     = (BLOCK_LEN > W_MAX) ? BLOCK_LEN : W_MAX;
    localparam int CNT_W       = $clog2(CNT_MAX + 1);

    nand_pkg::byte_t    mem [ARRAY_BYTES];
    nand_pkg::op_kind_e kind_q;
    nand_pkg::row_t     row_q;
    logic               busy_q;
    logic               xfer_q;  // Past the busy wait, moving bytes
    logic [CNT_W-1:0]   cnt_q;   // Down in the wait, up in the transfer
    logic [CNT_W-1:0]   wait_len;
    logic [CNT_W-1:0]   xfer_last;
    logic [ADDR_W-1:0]  page_addr;
    logic [ADDR_W-1:0]  erase_addr;

    always_comb begin
        case (req.kind)
            nand_pkg::LOAD:    wait_len = CNT_W'(`NAND_T_READ - 1);
            nand_pkg::PROGRAM: wait_len = CNT_W'(`NAND_T_PROG - 1);
            default:           wait_len = CNT_W'(`NAND_T_ERASE - 1);
        endcase
    end

    assign xfer_last  = (kind_q == nand_pkg::ERASE) ? CNT_W'(BLOCK_LEN - 1) : CNT_W'(PAGE_LEN - 1);
    assign page_addr  = {row_q, cnt_q[`NAND_COL_W-1:0]};
    assign erase_addr = {row_q[`NAND_ROW_W-1 -: BLK_W], cnt_q[SUB_W-1:0]}; // Whole block

    // Cache side, copy only on LOAD
    always_comb begin
        cache.we    = busy_q && xfer_q && (kind_q == nand_pkg::LOAD);
        cache.idx   = cnt_q[`NAND_COL_W-1:0];
        cache.wdata = mem[page_addr];
    end

    assign ryby = !busy_q;

    always_ff @(posedge RE_B or posedge CE_B) begin
        if (CE_B) begin
            busy_q <= 1'b0;
            xfer_q <= 1'b0;
            kind_q <= nand_pkg::LOAD;
            row_q  <= '0;
            cnt_q  <= '0;
        end else if (!busy_q) begin
            if (req.valid) begin
                busy_q <= 1'b1;
                xfer_q <= 1'b0;
                kind_q <= req.kind;
                row_q  <= req.row;
                cnt_q  <= wait_len;
            end
        end else if (!xfer_q) begin
            if (cnt_q == '0) begin
                xfer_q <= 1'b1; // Counter already at 0 for the first byte
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end else if (cnt_q == xfer_last) begin
            busy_q <= 1'b0; // Last byte moved, ready again
            xfer_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Flash cells
    always_ff @(posedge RE_B or posedge CE_B) begin
        if (CE_B) begin
            for (int i = 0; i < ARRAY_BYTES; i++) begin
                mem[i] <= 8'hFF; // Erased state
            end
        end else if (busy_q && xfer_q) begin
            case (kind_q)
                nand_pkg::PROGRAM: mem[page_addr] <= mem[page_addr] & cache_rdata; // 1 to 0 only
                nand_pkg::ERASE:   mem[erase_addr] <= 8'hFF;
                default: ;
            endcase
        end
    end

    // Decoder holds requests off while busy
    a_no_overlap: assert property (@(posedge RE_B) disable iff (CE_B)
        req.valid |-> !busy_q)
        else $error("array request arrived while an operation was running");

endmodule

`default_nettype wire

// File: nand_cfg.svh
// Geometry must stay powers of two; the row address is the block bits above the page bits
`ifndef NAND_CFG_SVH
`define NAND_CFG_SVH

// Array geometry
`define NAND_PAGE_BYTES       16   // Bytes per page
`define NAND_PAGES_PER_BLOCK  4    // Pages per block
`define NAND_BLOCKS           4    // Blocks in the array

// One address cycle each for column and row
`define NAND_COL_W            4    // log2 of page bytes
`define NAND_ROW_W            4    // 2 block bits, then 2 page bits

// Read ID sequence, maker code first
`define NAND_ID0              8'hC2
`define NAND_ID1              8'hF1
`define NAND_ID2              8'h80
`define NAND_ID3              8'h1D

// Busy clocks ahead of the array transfer
`define NAND_T_READ           8
`define NAND_T_PROG           20
`define NAND_T_ERASE          30

`endif

// File: nand_cmd_decoder.sv
// Commands other than 70 and FF are dropped while busy; one column and one row cycle per address
`default_nettype none

`include "nand_cfg.svh"

module nand_cmd_decoder (
    input  logic                 RE_B,
    input  logic                 CE_B,
    input  nand_pkg::host_cycle_t bus,
    input  logic                 ryby,
    input  nand_pkg::byte_t      cache_rdata,
    output nand_pkg::op_req_t    req,
    output logic                 cache_fill,
    output logic                 cache_wr,
    output logic                 cache_rd,
    output nand_pkg::col_t       col,
    output nand_pkg::byte_t      dout
);

    nand_pkg::dec_state_e state_q;
    nand_pkg::out_mode_e  mode_q;
    nand_pkg::nand_cmd_e  cmd;
    nand_pkg::col_t       col_q;
    nand_pkg::row_t       row_q;
    nand_pkg::byte_t      id_byte;
    logic [1:0]           addr_cyc_q; // 0 col next, 1 row next, 2 complete
    logic [1:0]           id_ptr_q;
    logic                 fill_q;
    logic                 is_cmd;
    logic                 is_addr;
    logic                 is_data;
    logic                 in_addr;

    assign cmd     = nand_pkg::nand_cmd_e'(bus.data);
    assign is_cmd  = bus.wr && bus.cle;
    assign is_addr = bus.wr && bus.ale && !bus.cle;
    assign is_data = bus.wr && !bus.cle && !bus.ale;
    assign in_addr = state_q inside {nand_pkg::READ_ADDR, nand_pkg::PROG_ADDR,
                                     nand_pkg::ERASE_ADDR};

    // Host port of the page cache
    assign cache_fill = fill_q;
    assign cache_wr   = is_data && (state_q == nand_pkg::PROG_DATA);
    assign cache_rd   = bus.rd && (mode_q == nand_pkg::DATA);
    assign col        = col_q;

    always_comb begin
        case (id_ptr_q)
            2'd0:    id_byte = `NAND_ID0;
            2'd1:    id_byte = `NAND_ID1;
            2'd2:    id_byte = `NAND_ID2;
            default: id_byte = `NAND_ID3;
        endcase
    end

    // Confirm goes out in the same cycle so busy shows one edge later
    always_comb begin
        req      = '0;
        req.row  = row_q;
        if (is_cmd && ryby) begin
            case (cmd)
                nand_pkg::CMD_READ_GO: begin
                    req.valid = (state_q == nand_pkg::READ_ADDR) && (addr_cyc_q == 2'd2);
                    req.kind  = nand_pkg::LOAD;
                end
                nand_pkg::CMD_PROG_GO: begin
                    req.valid = (state_q == nand_pkg::PROG_DATA); // Row already latched
                    req.kind  = nand_pkg::PROGRAM;
                end
                nand_pkg::CMD_ERASE_GO: begin
                    req.valid = (state_q == nand_pkg::ERASE_ADDR) && (addr_cyc_q == 2'd2);
                    req.kind  = nand_pkg::ERASE;
                end
                default: req.valid = 1'b0;
            endcase
        end
    end

    always_ff @(posedge RE_B or posedge CE_B) begin
        if (CE_B) begin
            state_q    <= nand_pkg::IDLE;
            mode_q     <= nand_pkg::NONE;
            col_q      <= '0;
            row_q      <= '0;
            addr_cyc_q <= 2'd0;
            id_ptr_q   <= 2'd0;
            fill_q     <= 1'b0;
            dout       <= 8'hFF;
        end else begin
            fill_q <= 1'b0; // Single-cycle pulse
            if (is_cmd) begin
                case (cmd)
                    nand_pkg::CMD_RESET: begin
                        state_q    <= nand_pkg::IDLE;
                        mode_q     <= nand_pkg::NONE;
                        addr_cyc_q <= 2'd0;
                    end
                    nand_pkg::CMD_STATUS: mode_q <= nand_pkg::STATUS; // Allowed while busy
                    default: begin
                        if (ryby) begin
                            state_q <= nand_pkg::IDLE; // Confirms and unknown codes land here
                            case (cmd)
                                nand_pkg::CMD_READ: begin
                                    mode_q     <= nand_pkg::DATA;
                                    state_q    <= nand_pkg::READ_ADDR;
                                    addr_cyc_q <= 2'd0;
                                end
                                nand_pkg::CMD_READ_GO: mode_q <= nand_pkg::DATA;
                                nand_pkg::CMD_READ_ID: begin
                                    mode_q   <= nand_pkg::ID;
                                    id_ptr_q <= 2'd0;
                                end
                                nand_pkg::CMD_PROG: begin
                                    mode_q     <= nand_pkg::NONE;
                                    state_q    <= nand_pkg::PROG_ADDR;
                                    addr_cyc_q <= 2'd0;
                                end
                                nand_pkg::CMD_ERASE: begin
                                    mode_q     <= nand_pkg::NONE;
                                    state_q    <= nand_pkg::ERASE_ADDR;
                                    addr_cyc_q <= 2'd1; // Row cycle only
                                end
                                default: ;
                            endcase
                        end
                    end
                endcase
            end else if (is_addr && in_addr) begin
                if (addr_cyc_q == 2'd0) begin
                    col_q      <= bus.data[`NAND_COL_W-1:0];
                    addr_cyc_q <= 2'd1;
                    fill_q     <= (state_q == nand_pkg::PROG_ADDR); // Page to FF and pointer to col
                end else if (addr_cyc_q == 2'd1) begin
                    row_q      <= bus.data[`NAND_ROW_W-1:0];
                    addr_cyc_q <= 2'd2;
                    if (state_q == nand_pkg::PROG_ADDR) state_q <= nand_pkg::PROG_DATA;
                end
            end
            // Output byte, held until the next rd
            if (bus.rd) begin
                case (mode_q)
                    nand_pkg::STATUS: dout <= {1'b1, ryby, ryby, 5'b0};
                    nand_pkg::ID: begin
                        dout     <= id_byte;
                        id_ptr_q <= id_ptr_q + 2'd1; // Wraps after ID3
                    end
                    nand_pkg::DATA: dout <= cache_rdata;
                    default: dout <= 8'hFF;
                endcase
            end
        end
    end

    // Engine turns busy one edge after each request
    a_req_ready: assert property (@(posedge RE_B) disable iff (CE_B)
        req.valid |=> !ryby)
        else $error("device stayed ready after an array request");

endmodule

`default_nettype wire

// File: nand_flash_top.sv
// Host strobes are sampled on each RE_B rising edge; no tri-state bus and no write protect
`default_nettype none

module nand_flash_top (
    input  logic                  RE_B,
    input  logic                  CE_B,
    input  nand_pkg::host_cycle_t bus,
    output nand_pkg::byte_t       dout,
    output logic                  ryby
);

    nand_pkg::op_req_t     req;         // Decoder to engine
    nand_pkg::cache_port_t eng;         // Engine to cache
    nand_pkg::byte_t       cache_rdata; // Host side read byte
    nand_pkg::byte_t       eng_rdata;   // Engine side read byte
    nand_pkg::col_t        col;
    logic                  cache_fill;
    logic                  cache_wr;
    logic                  cache_rd;

    nand_cmd_decoder i_decoder (
        .RE_B        (RE_B),
        .CE_B        (CE_B),
        .bus         (bus),
        .ryby        (ryby),
        .cache_rdata (cache_rdata),
        .req         (req),
        .cache_fill  (cache_fill),
        .cache_wr    (cache_wr),
        .cache_rd    (cache_rd),
        .col         (col),
        .dout        (dout)
    );

    nand_page_cache i_cache (
        .RE_B      (RE_B),
        .CE_B      (CE_B),
        .fill      (cache_fill),
        .wr        (cache_wr),
        .rd        (cache_rd),
        .col       (col),
        .wdata     (bus.data), // Data cycles write straight from the bus
        .eng       (eng),
        .rdata     (cache_rdata),
        .eng_rdata (eng_rdata)
    );

    nand_array_engine i_engine (
        .RE_B        (RE_B),
        .CE_B        (CE_B),
        .req         (req),
        .cache       (eng),
        .cache_rdata (eng_rdata),
        .ryby        (ryby)
    );

endmodule

`default_nettype wire

// File: nand_page_cache.sv
// Single page buffer; host pointer wraps at the page end, engine writes win over host writes
`default_nettype none

`include "nand_cfg.svh"

module nand_page_cache (
    input  logic                 RE_B,
    input  logic                 CE_B,
    input  logic                 fill,
    input  logic                 wr,
    input  logic                 rd,
    input  nand_pkg::col_t       col,
    input  nand_pkg::byte_t      wdata,
    input  nand_pkg::cache_port_t eng,
    output nand_pkg::byte_t      rdata,
    output nand_pkg::byte_t      eng_rdata
);

    localparam int PAGE_LEN = `NAND_PAGE_BYTES;

    nand_pkg::byte_t page [PAGE_LEN];
    nand_pkg::col_t  ptr_q; // Host byte pointer

    // Pointer goes to the latched column on fill and while the engine loads a page
    always_ff @(posedge RE_B or posedge CE_B) begin
        if (CE_B) begin
            ptr_q <= '0;
        end else if (fill || eng.we) begin
            ptr_q <= col;
        end else if (wr || rd) begin
            ptr_q <= ptr_q + 1'b1; // Sequential host access
        end
    end

    // Page storage
    always_ff @(posedge RE_B) begin
        if (fill) begin
            for (int i = 0; i < PAGE_LEN; i++) begin
                page[i] <= 8'hFF; // Unwritten columns program as FF
            end
        end else if (eng.we) begin
            page[eng.idx] <= eng.wdata; // Array to cache copy
        end else if (wr) begin
            page[ptr_q] <= wdata;
        end
    end

    assign rdata     = page[ptr_q];   // Host sees the byte under the pointer
    assign eng_rdata = page[eng.idx]; // Engine reads during program

    // Fill pulse never lands on a host data cycle or on an engine copy
    a_fill_alone: assert property (@(posedge RE_B) disable iff (CE_B)
        fill |-> !(wr || eng.we))
        else $error("page buffer clear collided with a write");

endmodule

`default_nettype wire

// File: nand_pkg.sv
// Field widths follow nand_cfg.svh; struct layouts are fixed and shared by every block
`default_nettype none

`include "nand_cfg.svh"

package nand_pkg;

    typedef logic [7:0]             byte_t;
    typedef logic [`NAND_COL_W-1:0] col_t;
    typedef logic [`NAND_ROW_W-1:0] row_t; // {block, page}

    // Only the commands the device still accepts
    typedef enum logic [7:0] {
        CMD_READ     = 8'h00,
        CMD_READ_GO  = 8'h30,
        CMD_READ_ID  = 8'h90,
        CMD_STATUS   = 8'h70,
        CMD_PROG     = 8'h80,
        CMD_PROG_GO  = 8'h10,
        CMD_ERASE    = 8'h60,
        CMD_ERASE_GO = 8'hD0,
        CMD_RESET    = 8'hFF
    } nand_cmd_e;

    typedef enum logic [2:0] {IDLE, READ_ADDR, PROG_ADDR, PROG_DATA, ERASE_ADDR} dec_state_e;

    typedef enum logic [1:0] {NONE, STATUS, ID, DATA} out_mode_e; // What a rd cycle returns

    typedef enum logic [1:0] {LOAD, PROGRAM, ERASE} op_kind_e;

    // One host bus cycle, sampled on each clock
    typedef struct packed {
        logic  cle;  // Command latch
        logic  ale;  // Address latch
        logic  wr;   // Write strobe
        logic  rd;   // Read strobe
        byte_t data;
    } host_cycle_t;

    // Array request, valid for a single clock
    typedef struct packed {
        logic     valid;
        op_kind_e kind;
        row_t     row;
    } op_req_t;

    // Engine side of the page cache
    typedef struct packed {
        logic  we;
        col_t  idx;
        byte_t wdata;
    } cache_port_t;

endpackage

`default_nettype wire

// File: tb_nand_table.svh
// Steps run in order and share array state; a READ checks all 16 columns, wrapping from col
`ifndef TB_NAND_TABLE_SVH
`define TB_NAND_TABLE_SVH

typedef enum logic [2:0] {OP_STATUS, OP_ID, OP_READ, OP_PROG, OP_ERASE} step_op_e;

// One table row
typedef struct packed {
    logic [8*12-1:0] name;    // Test name, ASCII
    step_op_e        op;
    nand_pkg::row_t  row;     // {block, page}
    nand_pkg::col_t  col;     // Start column
    nand_pkg::byte_t data;    // Byte count for PROG
    nand_pkg::byte_t exp_val; // Status while busy, or first byte returned
} step_t;

localparam int NUM_STEPS = 16;

localparam step_t STEPS [NUM_STEPS] = '{
    // name           op         row   col   data   exp_val
    '{"reset_status", OP_STATUS, 4'h0, 4'h0, 8'd0,  8'hE0},
    '{"read_id",      OP_ID,     4'h0, 4'h0, 8'd0,  8'hC2}, // Maker code first
    '{"read_erased",  OP_READ,   4'h3, 4'h5, 8'd0,  8'h80},
    '{"read_erased2", OP_READ,   4'hC, 4'h0, 8'd0,  8'h80},
    '{"prog_full",    OP_PROG,   4'h5, 4'h0, 8'd16, 8'h80},
    '{"read_full",    OP_READ,   4'h5, 4'h0, 8'd0,  8'h80},
    '{"prog_part",    OP_PROG,   4'h6, 4'h2, 8'd5,  8'h80}, // Rest of the page stays FF
    '{"read_part",    OP_READ,   4'h6, 4'h0, 8'd0,  8'h80},
    '{"prog_again",   OP_PROG,   4'h5, 4'h4, 8'd8,  8'h80}, // AND onto prog_full data
    '{"read_and",     OP_READ,   4'h5, 4'h3, 8'd0,  8'h80},
    '{"prog_other",   OP_PROG,   4'h9, 4'h0, 8'd16, 8'h80}, // Block 2
    '{"erase_blk1",   OP_ERASE,  4'h4, 4'h0, 8'd0,  8'h80},
    '{"read_wiped5",  OP_READ,   4'h5, 4'h0, 8'd0,  8'h80},
    '{"read_wiped6",  OP_READ,   4'h6, 4'h7, 8'd0,  8'h80},
    '{"read_kept",    OP_READ,   4'h9, 4'h0, 8'd0,  8'h80},
    '{"status_end",   OP_STATUS, 4'h0, 4'h0, 8'd0,  8'hE0}
};

`endif

// File: tb_nand_flash.sv
// Expected bytes come from a byte-level array model; every step waits for ready before the next
`default_nettype none

`include "nand_cfg.svh"

module tb_nand_flash;

    localparam int DRIVE_DLY     = 1;   // Input skew after the clock edge
    localparam int READY_TIMEOUT = 200; // Ready wait limit in cycles
    localparam int BLOCK_BYTES   = `NAND_PAGES_PER_BLOCK * `NAND_PAGE_BYTES;
    localparam int ARRAY_BYTES   = `NAND_BLOCKS * BLOCK_BYTES;
    localparam nand_pkg::byte_t STATUS_READY = 8'hE0;

    `include "tb_nand_table.svh"

    logic                  RE_B;
    logic                  CE_B;
    nand_pkg::host_cycle_t bus;
    nand_pkg::byte_t       dout;
    logic                  ryby;

    nand_pkg::byte_t model_mem [ARRAY_BYTES]; // Expected array contents
    nand_pkg::byte_t id_exp [4];
    logic [31:0]     lcg_state;
    int              errors;
    int              checks;

    nand_flash_top i_dut (
        .RE_B (RE_B),
        .CE_B (CE_B),
        .bus  (bus),
        .dout (dout),
        .ryby (ryby)
    );

    initial begin
        RE_B = 1'b0;
        forever #4 RE_B = ~RE_B; // Period 8
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_byte(input string name, input nand_pkg::byte_t exp,
                              input nand_pkg::byte_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Status bit 6 mirrors the ready/busy pin
    task automatic check_status(input string name, input nand_pkg::byte_t exp,
                                input nand_pkg::byte_t act, input logic act_ryby);
        checks++;
        if (act !== exp || act_ryby !== exp[6]) begin
            errors++;
            $display("error %s: expected status %h ryby %b, actual status %h ryby %b",
                     name, exp, exp[6], act, act_ryby);
        end
    endtask

    task automatic check_ryby(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected ryby %b, actual ryby %b", name, exp, act);
        end
    endtask

    task automatic put_cycle(input nand_pkg::host_cycle_t c);
        @(posedge RE_B);
        #DRIVE_DLY;
        bus = c;
    endtask

    task automatic bus_idle();
        @(posedge RE_B);
        #DRIVE_DLY;
        bus = '0;
    endtask

    task automatic send_cmd(input nand_pkg::byte_t b);
        put_cycle('{cle: 1'b1, ale: 1'b0, wr: 1'b1, rd: 1'b0, data: b});
    endtask

    task automatic send_addr(input nand_pkg::byte_t b);
        put_cycle('{cle: 1'b0, ale: 1'b1, wr: 1'b1, rd: 1'b0, data: b});
    endtask

    task automatic send_data(input nand_pkg::byte_t b);
        put_cycle('{cle: 1'b0, ale: 1'b0, wr: 1'b1, rd: 1'b0, data: b});
    endtask

    // dout settles on the edge that takes rd
    task automatic read_byte(output nand_pkg::byte_t v, output logic rb);
        put_cycle('{cle: 1'b0, ale: 1'b0, wr: 1'b0, rd: 1'b1, data: 8'h00});
        bus_idle();
        v  = dout;
        rb = ryby;
    endtask

    task automatic wait_ready(input string name);
        int n;
        n = 0;
        while (ryby !== 1'b1 && n < READY_TIMEOUT) begin
            @(posedge RE_B);
            #DRIVE_DLY;
            n++;
        end
        if (ryby !== 1'b1) begin
            errors++;
            $display("%s: device still busy after %0d cycles, gave up waiting", name, n);
        end
    endtask

    // Confirm already driven; busy must show on the edge that takes it
    task automatic confirm_busy(input string name, input nand_pkg::byte_t exp_busy);
        nand_pkg::byte_t v;
        logic            rb;
        bus_idle();
        check_ryby({name, "_confirm"}, 1'b0, ryby);
        send_cmd(8'h70);
        read_byte(v, rb);
        check_status({name, "_busy"}, exp_busy, v, rb);
        wait_ready(name);
        send_cmd(8'h70);
        read_byte(v, rb);
        check_status({name, "_ready"}, STATUS_READY, v, rb);
    endtask

    task automatic run_step(input step_t s);
        string           name;
        nand_pkg::byte_t page_buf [`NAND_PAGE_BYTES];
        nand_pkg::byte_t v;
        logic            rb;
        int              base;
        int              blk_base;
        name     = $sformatf("%0s", s.name);
        base     = int'(s.row) * `NAND_PAGE_BYTES;
        blk_base = (int'(s.row) / `NAND_PAGES_PER_BLOCK) * BLOCK_BYTES;
        case (s.op)
            OP_STATUS: begin
                send_cmd(8'h70);
                read_byte(v, rb);
                check_status(name, s.exp_val, v, rb);
            end
            OP_ID: begin
                send_cmd(8'h90);
                for (int k = 0; k < 5; k++) begin // Fifth read shows the wrap
                    read_byte(v, rb);
                    check_byte($sformatf("%s[%0d]", name, k),
                               (k == 0) ? s.exp_val : id_exp[k % 4], v);
                end
            end
            OP_READ: begin
                send_cmd(8'h00);
                send_addr(nand_pkg::byte_t'(s.col));
                send_addr(nand_pkg::byte_t'(s.row));
                send_cmd(8'h30);
                confirm_busy(name, s.exp_val);
                send_cmd(8'h00); // Back to data output
                for (int k = 0; k < `NAND_PAGE_BYTES; k++) begin
                    read_byte(v, rb);
                    check_byte($sformatf("%s[%0d]", name, k),
                               model_mem[base + (int'(s.col) + k) % `NAND_PAGE_BYTES], v);
                end
            end
            OP_PROG: begin
                for (int i = 0; i < `NAND_PAGE_BYTES; i++) begin
                    page_buf[i] = 8'hFF;
                end
                send_cmd(8'h80);
                send_addr(nand_pkg::byte_t'(s.col));
                send_addr(nand_pkg::byte_t'(s.row));
                for (int k = 0; k < int'(s.data); k++) begin
                    lcg_state = lcg_next(lcg_state);
                    page_buf[(int'(s.col) + k) % `NAND_PAGE_BYTES] = lcg_state[31:24];
                    send_data(lcg_state[31:24]);
                end
                send_cmd(8'h10);
                confirm_busy(name, s.exp_val);
                for (int i = 0; i < `NAND_PAGE_BYTES; i++) begin
                    model_mem[base + i] = model_mem[base + i] & page_buf[i]; // Clear only
                end
            end
            OP_ERASE: begin
                send_cmd(8'h60);
                send_addr(nand_pkg::byte_t'(s.row));
                send_cmd(8'hD0);
                confirm_busy(name, s.exp_val);
                for (int i = 0; i < BLOCK_BYTES; i++) begin
                    model_mem[blk_base + i] = 8'hFF;
                end
            end
            default: begin
                errors++;
                $display("%s: table step has an unknown operation", name);
            end
        endcase
    endtask

    initial begin
        bus       = '0;
        CE_B      = 1'b1;
        errors    = 0;
        checks    = 0;
        lcg_state = 32'h746b_e951;
        id_exp[0] = `NAND_ID0;
        id_exp[1] = `NAND_ID1;
        id_exp[2] = `NAND_ID2;
        id_exp[3] = `NAND_ID3;
        for (int i = 0; i < ARRAY_BYTES; i++) begin
            model_mem[i] = 8'hFF; // Erased array
        end
        repeat (3) @(posedge RE_B);
        #DRIVE_DLY;
        CE_B = 1'b0;
        check_byte("reset_dout", 8'hFF, dout);
        check_ryby("reset_ryby", 1'b1, ryby);
        for (int i = 0; i < NUM_STEPS; i++) begin
            run_step(STEPS[i]);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
